//--- source/isaPkg.sv
`default_nettype none

package isaPkg;

	// ==================================================
	// Instruction format
	// ==================================================
	typedef logic [47:0] instr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;
	typedef logic [4:0] regNum_t;

	localparam int opcodeHi = 5;
	localparam int opcodeLo = 0;
	localparam int lenCodeHi = 7;
	localparam int lenCodeLo = 6;
	localparam int raHi = 12;
	localparam int raLo = 8;
	localparam int rbHi = 17;
	localparam int rbLo = 13;
	localparam int rcHi = 22;
	localparam int rcLo = 18;
	localparam int functHi = 31;
	localparam int functLo = 26;
	localparam int shortConstHi = 31;
	localparam int shortConstLo = 18;
	localparam int longConstHi = 47;
	localparam int longConstLo = 18;

	// Single-bit modifiers
	localparam int amoImmBit = 31;
	localparam int jmpAbsBit = 7;

	// Length codes, anything else is a two byte form
	localparam logic [1:0] LEN4 = 2'b00;
	localparam logic [1:0] LEN6 = 2'b01;

	// ==================================================
	// Major opcodes
	// ==================================================
	localparam opcode_t BRK   = 6'h00;
	localparam opcode_t R2    = 6'h02;
	localparam opcode_t ADDI  = 6'h04;
	localparam opcode_t MULI  = 6'h06;
	localparam opcode_t ANDI  = 6'h08;
	localparam opcode_t ORI   = 6'h09;
	localparam opcode_t FLOAT = 6'h0F;
	localparam opcode_t LB    = 6'h13;
	localparam opcode_t SB    = 6'h15;
	localparam opcode_t JAL   = 6'h18;
	localparam opcode_t CALL  = 6'h19;
	localparam opcode_t LW    = 6'h20;
	localparam opcode_t SW    = 6'h24;
	localparam opcode_t CAS   = 6'h25;
	localparam opcode_t JMP   = 6'h28;
	localparam opcode_t RET   = 6'h29;
	localparam opcode_t AMO   = 6'h2E;
	localparam opcode_t BCC   = 6'h30;
	localparam opcode_t BEQI  = 6'h32;

	// R2 function codes
	localparam funct_t ADD    = 6'h04;
	localparam funct_t SUB    = 6'h05;
	localparam funct_t AND    = 6'h08;
	localparam funct_t OR     = 6'h09;
	localparam funct_t LWX    = 6'h12;
	localparam funct_t SWX    = 6'h16;
	localparam funct_t CASX   = 6'h25;
	localparam funct_t MIN    = 6'h2C;
	localparam funct_t MAX    = 6'h2D;
	localparam funct_t RTI    = 6'h32;
	localparam funct_t MUL    = 6'h3A;
	localparam funct_t DIVMOD = 6'h3E;

endpackage

`default_nettype wire

//--- source/decodeBusPkg.sv
`default_nettype none

package decodeBusPkg;

	typedef logic [63:0] const_t;
	typedef logic [2:0] instrLen_t;
	typedef logic [95:0] decodeBus_t;

	// ==================================================
	// Decode bus field positions
	// ==================================================
	localparam int constLo = 0;
	localparam int constHi = 63;
	localparam int lengthLo = 64;
	localparam int lengthHi = 66;
	localparam int hasConstBit = 67;
	localparam int src1ValidBit = 68;
	localparam int src2ValidBit = 69;
	localparam int src3ValidBit = 70;
	localparam int branchTakenBit = 71;
	localparam int aluBit = 72;
	localparam int alu0OnlyBit = 73;
	localparam int fpuBit = 74;
	localparam int flowCtrlBit = 75;
	localparam int canExceptionBit = 76;
	localparam int loadBit = 77;
	localparam int preloadBit = 78;
	localparam int memBit = 79;
	localparam int memNdxBit = 80;
	localparam int rmwBit = 81;
	localparam int jmpBit = 82;
	localparam int branchBit = 83;
	localparam int syncBit = 84;
	localparam int regWriteBit = 85;
	// Bits 95..86 reserved, read as zero

endpackage

`default_nettype wire

//--- source/decodeIfs.sv
`default_nettype none

// Execution unit and control flow flags
interface unitFlagsIf;
	logic alu;
	logic alu0Only;
	logic fpu;
	logic flowCtrl;
	logic branch;
	logic jmp;
	logic sync;
	logic canException;

	modport classifier (output alu, alu0Only, fpu, flowCtrl, branch, jmp, sync, canException);
	modport sink (input alu, alu0Only, fpu, flowCtrl, branch, jmp, sync, canException);
endinterface

// Memory access flags
interface memFlagsIf;
	logic load;
	logic mem;
	logic memNdx;
	logic rmw;

	modport classifier (output load, mem, memNdx, rmw);
	modport sink (input load, mem, memNdx, rmw);
endinterface

// Source operand readiness and register writer
interface operandIf;
	logic src1Valid;
	logic src2Valid;
	logic src3Valid;
	logic regWriter;

	modport classifier (output src1Valid, src2Valid, src3Valid, regWriter);
	modport sink (input src1Valid, src2Valid, src3Valid, regWriter);
endinterface

`default_nettype wire

//--- source/immediateDecoder.sv
`default_nettype none

module immediateDecoder (
	input  wire isaPkg::instr_t         instr_i,
	output decodeBusPkg::const_t        constant_o,
	output decodeBusPkg::instrLen_t     length_o,
	output logic                        hasConst_o
);
	import isaPkg::*;

	logic [1:0] lenCode;
	opcode_t opcode;
	logic signed [longConstHi-longConstLo:0] longConst;
	logic signed [shortConstHi-shortConstLo:0] shortConst;

	assign lenCode = instr_i[lenCodeHi:lenCodeLo];
	assign opcode = instr_i[opcodeHi:opcodeLo];
	assign longConst = instr_i[longConstHi:longConstLo];
	assign shortConst = instr_i[shortConstHi:shortConstLo];

	// Signed operands, so both arms sign extend to 64 bits
	assign constant_o = (lenCode == LEN6) ? longConst : shortConst;

	// Byte count of the instruction
	always_comb
	begin
		case (lenCode)
			LEN4: length_o = 3'd4;
			LEN6: length_o = 3'd6;
			default: length_o = 3'd2;
		endcase
	end

	assign hasConst_o = opcode inside {ADDI, ANDI, ORI, MULI, LB, LW, SB, SW, CAS,
		JAL, CALL, RET};

endmodule

`default_nettype wire

//--- source/memClassifier.sv
`default_nettype none

module memClassifier (
	input  wire isaPkg::instr_t   instr_i,
	memFlagsIf.classifier         flags
);
	import isaPkg::*;

	opcode_t opcode;
	funct_t funct;
	logic isR2;
	logic load;

	assign opcode = instr_i[opcodeHi:opcodeLo];
	assign funct = instr_i[functHi:functLo];
	assign isR2 = (opcode == R2);

	assign load = (opcode inside {LB, LW}) | (isR2 & (funct == LWX));
	assign flags.load = load;

	// Any access to data memory
	assign flags.mem = load | (opcode inside {SB, SW, CAS, AMO}) |
		(isR2 & (funct inside {SWX, CASX}));

	// Register indexed forms
	assign flags.memNdx = isR2 & (funct inside {LWX, SWX, CASX});

	// Atomic read-modify-write
	assign flags.rmw = (opcode inside {CAS, AMO}) | (isR2 & (funct == CASX));

endmodule

`default_nettype wire

//--- source/unitClassifier.sv
`default_nettype none

module unitClassifier (
	input  wire isaPkg::instr_t   instr_i,
	memFlagsIf.sink               mem,
	unitFlagsIf.classifier        flags
);
	import isaPkg::*;

	opcode_t opcode;
	funct_t funct;
	logic isR2;
	logic isFloat;
	logic flowCtrl;

	assign opcode = instr_i[opcodeHi:opcodeLo];
	assign funct = instr_i[functHi:functLo];
	assign isR2 = (opcode == R2);
	assign isFloat = (opcode == FLOAT);

	// ==================================================
	// Unit selection
	// ==================================================
	always_comb
	begin
		case (opcode)
			BRK, BCC, BEQI, JMP, JAL, CALL, RET: flowCtrl = 1'b1;
			R2: flowCtrl = (funct == RTI);
			default: flowCtrl = 1'b0;
		endcase
	end

	assign flags.flowCtrl = flowCtrl;
	assign flags.fpu = isFloat;
	assign flags.alu = ~(flowCtrl | isFloat);

	// Multiplier, divider and indexed address adder sit on ALU0 only
	assign flags.alu0Only = (opcode == MULI) |
		(isR2 & (funct inside {MUL, DIVMOD, MIN, MAX, LWX, SWX}));

	// ==================================================
	// Control flow
	// ==================================================
	assign flags.branch = opcode inside {BCC, BEQI};
	assign flags.jmp = (opcode == JMP) & ~instr_i[jmpAbsBit];
	assign flags.sync = (opcode == BRK) | (isR2 & (funct == RTI));

	// Memory ops can always fault, so mem is folded in here
	always_comb
	begin
		case (opcode)
			ADDI, MULI, FLOAT, BCC, BEQI: flags.canException = 1'b1;
			R2: flags.canException = (funct inside {ADD, SUB, MUL, DIVMOD, RTI}) | mem.mem;
			default: flags.canException = mem.mem;
		endcase
	end

endmodule

`default_nettype wire

//--- source/operandValidity.sv
`default_nettype none

module operandValidity (
	input  wire isaPkg::instr_t   instr_i,
	operandIf.classifier          flags
);
	import isaPkg::*;

	opcode_t opcode;
	funct_t funct;
	logic isR2;
	logic raZero;
	logic rbZero;
	logic rcZero;

	assign opcode = instr_i[opcodeHi:opcodeLo];
	assign funct = instr_i[functHi:functLo];
	assign isR2 = (opcode == R2);

	// r0 reads as zero, so it never waits on a producer
	assign raZero = (instr_i[raHi:raLo] == '0);
	assign rbZero = (instr_i[rbHi:rbLo] == '0);
	assign rcZero = (instr_i[rcHi:rcLo] == '0);

	// ==================================================
	// Source operands
	// ==================================================
	assign flags.src1Valid = (opcode inside {R2, BCC, BEQI, ADDI, ANDI, ORI, MULI,
		LB, LW, SB, SW, CAS, AMO, JAL, RET}) ? raZero : 1'b1;

	always_comb
	begin
		case (opcode)
			R2, BCC, SB, SW, CAS, RET: flags.src2Valid = rbZero;
			// Immediate AMO has no Rb operand
			AMO: flags.src2Valid = instr_i[amoImmBit] | rbZero;
			default: flags.src2Valid = 1'b1;
		endcase
	end

	assign flags.src3Valid = (isR2 & (funct inside {SWX, CASX})) ? rcZero : 1'b1;

	// Instructions that produce a register result
	always_comb
	begin
		case (opcode)
			R2: flags.regWriter = funct inside {ADD, SUB, AND, OR, MUL, DIVMOD, MIN, MAX,
				LWX, CASX};
			ADDI, ANDI, ORI, MULI: flags.regWriter = 1'b1;
			LB, LW, CAS, AMO: flags.regWriter = 1'b1;
			JAL, CALL, RET: flags.regWriter = 1'b1;
			default: flags.regWriter = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- source/decodeRegister.sv
`default_nettype none

module decodeRegister (
	input  wire                         clk,
	input  wire                         reset_i,
	input  wire                         idValid_i,
	input  wire [4:0]                   id_i,
	input  wire isaPkg::regNum_t        rt_i,
	input  wire                         predictTaken_i,
	input  wire decodeBusPkg::const_t   constant_i,
	input  wire decodeBusPkg::instrLen_t length_i,
	input  wire                         hasConst_i,
	unitFlagsIf.sink                    unit,
	memFlagsIf.sink                     mem,
	operandIf.sink                      operand,
	output decodeBusPkg::decodeBus_t    decodeBus_o,
	output logic [4:0]                  id_o,
	output logic                        idValid_o
);
	import decodeBusPkg::*;

	decodeBus_t busNext;
	logic rtZero;

	// A load into r0 only warms the cache, and r0 is never written
	assign rtZero = (rt_i == '0);

	// ==================================================
	// Bus assembly
	// ==================================================
	always_comb
	begin
		busNext = '0;
		busNext[constHi:constLo] = constant_i;
		busNext[lengthHi:lengthLo] = length_i;
		busNext[hasConstBit] = hasConst_i;
		busNext[src1ValidBit] = operand.src1Valid;
		busNext[src2ValidBit] = operand.src2Valid;
		busNext[src3ValidBit] = operand.src3Valid;
		busNext[branchTakenBit] = unit.branch & predictTaken_i;
		busNext[aluBit] = unit.alu;
		busNext[alu0OnlyBit] = unit.alu0Only;
		busNext[fpuBit] = unit.fpu;
		busNext[flowCtrlBit] = unit.flowCtrl;
		busNext[canExceptionBit] = unit.canException;
		busNext[loadBit] = mem.load;
		busNext[preloadBit] = mem.load & rtZero;
		busNext[memBit] = mem.mem;
		busNext[memNdxBit] = mem.memNdx;
		busNext[rmwBit] = mem.rmw;
		busNext[jmpBit] = unit.jmp;
		busNext[branchBit] = unit.branch;
		busNext[syncBit] = unit.sync;
		busNext[regWriteBit] = operand.regWriter & ~rtZero;
	end

	// Single pipeline stage, loaded every cycle
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			decodeBus_o <= '0;
			id_o <= '0;
			idValid_o <= 1'b0;
		end
		else
		begin
			decodeBus_o <= busNext;
			id_o <= id_i;
			idValid_o <= idValid_i;
		end
	end

endmodule

`default_nettype wire

//--- source/instrDecoder.sv
`default_nettype none

module instrDecoder (
	input  wire                         clk,
	input  wire                         reset_i,
	input  wire                         idValid_i,
	input  wire [4:0]                   id_i,
	input  wire isaPkg::instr_t         instr_i,
	input  wire isaPkg::regNum_t        rt_i,
	input  wire                         predictTaken_i,
	output decodeBusPkg::decodeBus_t    decodeBus_o,
	output logic [4:0]                  id_o,
	output logic                        idValid_o
);
	import decodeBusPkg::*;

	const_t constant;
	instrLen_t length;
	logic hasConst;

	unitFlagsIf unitFlags ();
	memFlagsIf memFlags ();
	operandIf operand ();

	// ==================================================
	// Combinational classifiers
	// ==================================================
	immediateDecoder immediateDecoder_inst (
		.instr_i    (instr_i),
		.constant_o (constant),
		.length_o   (length),
		.hasConst_o (hasConst)
	);

	memClassifier memClassifier_inst (
		.instr_i (instr_i),
		.flags   (memFlags.classifier)
	);

	unitClassifier unitClassifier_inst (
		.instr_i (instr_i),
		.mem     (memFlags.sink),
		.flags   (unitFlags.classifier)
	);

	operandValidity operandValidity_inst (
		.instr_i (instr_i),
		.flags   (operand.classifier)
	);

	// Output register
	decodeRegister decodeRegister_inst (
		.clk            (clk),
		.reset_i        (reset_i),
		.idValid_i      (idValid_i),
		.id_i           (id_i),
		.rt_i           (rt_i),
		.predictTaken_i (predictTaken_i),
		.constant_i     (constant),
		.length_i       (length),
		.hasConst_i     (hasConst),
		.unit           (unitFlags.sink),
		.mem            (memFlags.sink),
		.operand        (operand.sink),
		.decodeBus_o    (decodeBus_o),
		.id_o           (id_o),
		.idValid_o      (idValid_o)
	);

endmodule

`default_nettype wire

//--- include/decodeRefModel.svh
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

// Expected decode bus, written as flat per-field rules
// Needs isaPkg and decodeBusPkg imported where it is included
function automatic decodeBus_t expectedBus(instr_t instr, regNum_t rt, logic predictTaken);
	decodeBus_t bus;
	opcode_t op;
	funct_t fn;
	logic r2;
	logic isLoad;
	logic isMem;
	logic isBr;
	logic isFc;
	logic rfw;
	op = instr[opcodeHi:opcodeLo];
	fn = instr[functHi:functLo];
	r2 = (op == R2);
	isLoad = (op == LB) || (op == LW) || (r2 && fn == LWX);
	isMem = isLoad || op inside {SB, SW, CAS, AMO} || (r2 && fn inside {SWX, CASX});
	isBr = op inside {BCC, BEQI};
	isFc = op inside {BRK, BCC, BEQI, JMP, JAL, CALL, RET} || (r2 && fn == RTI);
	rfw = op inside {ADDI, ANDI, ORI, MULI, LB, LW, CAS, AMO, JAL, CALL, RET} ||
		(r2 && fn inside {ADD, SUB, AND, OR, MUL, DIVMOD, MIN, MAX, LWX, CASX});
	bus = '0;
	if (instr[lenCodeHi:lenCodeLo] == LEN6)
		bus[constHi:constLo] = {{34{instr[47]}}, instr[47:18]};
	else
		bus[constHi:constLo] = {{50{instr[31]}}, instr[31:18]};
	case (instr[lenCodeHi:lenCodeLo])
		LEN4: bus[lengthHi:lengthLo] = 3'd4;
		LEN6: bus[lengthHi:lengthLo] = 3'd6;
		default: bus[lengthHi:lengthLo] = 3'd2;
	endcase
	bus[hasConstBit] = op inside {ADDI, ANDI, ORI, MULI, LB, LW, SB, SW, CAS, JAL, CALL, RET};
	bus[src1ValidBit] = !(op inside {R2, BCC, BEQI, ADDI, ANDI, ORI, MULI, LB, LW, SB, SW,
		CAS, AMO, JAL, RET}) || instr[raHi:raLo] == 0;
	bus[src2ValidBit] = (op == AMO) ? (instr[amoImmBit] || instr[rbHi:rbLo] == 0) :
		(!(op inside {R2, BCC, SB, SW, CAS, RET}) || instr[rbHi:rbLo] == 0);
	bus[src3ValidBit] = !(r2 && fn inside {SWX, CASX}) || instr[rcHi:rcLo] == 0;
	bus[branchTakenBit] = isBr && predictTaken;
	bus[aluBit] = !(isFc || op == FLOAT);
	bus[alu0OnlyBit] = op == MULI || (r2 && fn inside {MUL, DIVMOD, MIN, MAX, LWX, SWX});
	bus[fpuBit] = (op == FLOAT);
	bus[flowCtrlBit] = isFc;
	bus[canExceptionBit] = isMem || op inside {ADDI, MULI, FLOAT, BCC, BEQI} ||
		(r2 && fn inside {ADD, SUB, MUL, DIVMOD, RTI});
	bus[loadBit] = isLoad;
	bus[preloadBit] = isLoad && rt == 0;
	bus[memBit] = isMem;
	bus[memNdxBit] = r2 && fn inside {LWX, SWX, CASX};
	bus[rmwBit] = op inside {CAS, AMO} || (r2 && fn == CASX);
	bus[jmpBit] = (op == JMP) && !instr[jmpAbsBit];
	bus[branchBit] = isBr;
	bus[syncBit] = (op == BRK) || (r2 && fn == RTI);
	bus[regWriteBit] = rfw && rt != 0;
	return bus;
endfunction

`endif

//--- sim/instrDecoderTb.sv
`default_nettype none

module instrDecoderTb;
	import isaPkg::*;
	import decodeBusPkg::*;

	`include "decodeRefModel.svh"

	localparam int lenReps = 16;
	localparam int opReps = 4;
	localparam int operandReps = 200;
	localparam int streamReps = 300;
	localparam int numVectors = 4 * lenReps + (19 + 12) * 2 * opReps + operandReps + streamReps;

	logic clk;
	logic reset_i;
	logic idValid_i;
	logic [4:0] id_i;
	instr_t instr_i;
	regNum_t rt_i;
	logic predictTaken_i;
	decodeBus_t decodeBus_o;
	logic [4:0] id_o;
	logic idValid_o;

	decodeBus_t expBus;
	logic [4:0] expId;
	logic expValid;
	logic armed;
	integer seed;
	opcode_t opList[$];
	funct_t functList[$];

	instrDecoder instrDecoder_inst (
		.clk            (clk),
		.reset_i        (reset_i),
		.idValid_i      (idValid_i),
		.id_i           (id_i),
		.instr_i        (instr_i),
		.rt_i           (rt_i),
		.predictTaken_i (predictTaken_i),
		.decodeBus_o    (decodeBus_o),
		.id_o           (id_o),
		.idValid_o      (idValid_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==================================================
	// Helpers
	// ==================================================
	function automatic logic [31:0] nextRandom();
		return $random(seed);
	endfunction

	function automatic opcode_t randomOpcode();
		logic [31:0] r;
		r = nextRandom();
		return opList[r[7:0] % opList.size()];
	endfunction

	function automatic funct_t randomFunct();
		logic [31:0] r;
		r = nextRandom();
		return functList[r[7:0] % functList.size()];
	endfunction

	// Half the time rt is r0
	function automatic regNum_t randomRt();
		logic [31:0] r;
		r = nextRandom();
		return r[0] ? 5'd0 : r[8:4];
	endfunction

	function automatic instr_t makeInstr(opcode_t op, funct_t fn);
		logic [31:0] hi;
		logic [31:0] lo;
		instr_t ins;
		hi = nextRandom();
		lo = nextRandom();
		ins = {hi[15:0], lo};
		ins[opcodeHi:opcodeLo] = op;
		if (op == R2)
			ins[functHi:functLo] = fn;
		return ins;
	endfunction

	// Clear register fields often so the zero paths get exercised
	function automatic instr_t forceZeros(instr_t ins);
		logic [31:0] r;
		r = nextRandom();
		if (r[0])
			ins[raHi:raLo] = '0;
		if (r[1])
			ins[rbHi:rbLo] = '0;
		if (r[2])
			ins[rcHi:rcLo] = '0;
		return ins;
	endfunction

	task automatic applyVector(input instr_t ins, input regNum_t rt, input logic pt,
		input logic valid);
		logic [31:0] r;
		r = nextRandom();
		@(negedge clk);
		instr_i = ins;
		rt_i = rt;
		predictTaken_i = pt;
		idValid_i = valid;
		id_i = r[4:0];
	endtask

	task automatic checkValue(input string name, input logic [95:0] actual,
		input logic [95:0] expected);
		if (actual !== expected)
		begin
			$display("Error at time %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("CHECKS FAILED");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	// ==================================================
	// Expectation and comparison
	// ==================================================
	always @(posedge clk)
	begin
		expBus <= reset_i ? '0 : expectedBus(instr_i, rt_i, predictTaken_i);
		expId <= reset_i ? 5'd0 : id_i;
		expValid <= reset_i ? 1'b0 : idValid_i;
		armed <= 1'b1;
	end

	// Outputs only move on the rising edge, so the falling edge is a safe sample point
	always @(negedge clk)
	begin
		if (armed === 1'b1)
		begin
			checkValue("decodeBus_o", decodeBus_o, expBus);
			checkValue("id_o", id_o, expId);
			checkValue("idValid_o", idValid_o, expValid);
		end
	end

	initial
	begin
		#((numVectors + 20) * 100);
		$display("CHECKS FAILED");
		$fatal(1, "Timeout: the test did not finish in the expected time");
	end

	// ==================================================
	// Stimulus
	// ==================================================
	initial
	begin
		instr_t ins;
		logic [31:0] r;
		seed = 32'h4009_e563;
		armed = 1'b0;
		reset_i = 1'b1;
		// Live inputs during reset, the outputs must still clear
		idValid_i = 1'b1;
		id_i = 5'h1f;
		instr_i = '0;
		rt_i = '0;
		predictTaken_i = 1'b0;
		opList = '{BRK, R2, ADDI, MULI, ANDI, ORI, FLOAT, LB, SB, JAL, CALL, LW, SW, CAS,
			JMP, RET, AMO, BCC, BEQI};
		functList = '{ADD, SUB, AND, OR, LWX, SWX, CASX, MIN, MAX, RTI, MUL, DIVMOD};
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;

		// Length codes and constants
		for (int lc = 0; lc < 4; lc++)
			for (int k = 0; k < lenReps; k++)
			begin
				ins = makeInstr(randomOpcode(), randomFunct());
				ins[lenCodeHi:lenCodeLo] = lc[1:0];
				applyVector(ins, randomRt(), 1'b0, 1'b1);
			end

		// Each opcode and R2 function with both prediction values
		for (int i = 0; i < opList.size(); i++)
			for (int k = 0; k < opReps; k++)
			begin
				applyVector(makeInstr(opList[i], randomFunct()), randomRt(), 1'b0, 1'b1);
				applyVector(makeInstr(opList[i], randomFunct()), randomRt(), 1'b1, 1'b1);
			end
		for (int i = 0; i < functList.size(); i++)
			for (int k = 0; k < opReps; k++)
			begin
				applyVector(makeInstr(R2, functList[i]), randomRt(), 1'b0, 1'b1);
				applyVector(makeInstr(R2, functList[i]), randomRt(), 1'b1, 1'b1);
			end

		// Operand fields and rt
		for (int k = 0; k < operandReps; k++)
		begin
			r = nextRandom();
			ins = forceZeros(makeInstr(randomOpcode(), randomFunct()));
			applyVector(ins, randomRt(), r[0], 1'b1);
		end

		// Back to back stream, some with opcodes outside the table
		for (int k = 0; k < streamReps; k++)
		begin
			r = nextRandom();
			if (r[2])
				ins = makeInstr(r[13:8], r[21:16]);
			else
				ins = forceZeros(makeInstr(randomOpcode(), randomFunct()));
			applyVector(ins, randomRt(), r[0], r[1]);
		end

		repeat (2) @(negedge clk);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
source/isaPkg.sv
source/decodeBusPkg.sv
source/decodeIfs.sv
source/immediateDecoder.sv
source/memClassifier.sv
source/unitClassifier.sv
source/operandValidity.sv
source/decodeRegister.sv
source/instrDecoder.sv
sim/instrDecoderTb.sv

//--- Bender.yml
package:
  name: instr_decoder

sources:
  - files:
      - source/isaPkg.sv
      - source/decodeBusPkg.sv
      - source/decodeIfs.sv
      - source/immediateDecoder.sv
      - source/memClassifier.sv
      - source/unitClassifier.sv
      - source/operandValidity.sv
      - source/decodeRegister.sv
      - source/instrDecoder.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/instrDecoderTb.sv
